/* logic/sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

    // Screen x or y position, also used for the sprite width
    typedef logic [9:0] coord_t;

    // Linear framebuffer write address
    typedef logic [17:0] fb_addr_t;

    // Palette index, and the offset added to every pixel
    typedef logic [3:0] color_t;

    // Bits per pixel selector
    typedef logic [1:0] color_mode_t;

    // One byte of packed sprite data
    typedef logic [7:0] sprite_byte_t;

    // Row stride of the framebuffer in pixels
    localparam int unsigned screen_width = 640;

    // Color mode encodings, two codes map to 1 bpp
    localparam color_mode_t mode_1bpp     = 2'b00;
    localparam color_mode_t mode_1bpp_alt = 2'b01;
    localparam color_mode_t mode_2bpp     = 2'b10;
    localparam color_mode_t mode_4bpp     = 2'b11;

    // Unpacker FSM
    typedef enum logic {
        idle,
        emitting
    } unpack_state_t;

endpackage

`default_nettype wire

/* logic/sprite_byte_if.sv */
`default_nettype none

interface sprite_byte_if;

    // One cycle marker for a freshly captured byte
    logic                     byte_strobe;

    // Held stable from one strobe to the next
    sprite_pkg::sprite_byte_t byte_data;
    sprite_pkg::color_mode_t  mode;
    sprite_pkg::color_t       palette;

    modport source (
        output byte_strobe,
        output byte_data,
        output mode,
        output palette
    );

    modport sink (
        input byte_strobe,
        input byte_data,
        input mode,
        input palette
    );

endinterface

`default_nettype wire

/* logic/sprite_byte_capture.sv */
`default_nettype none

module sprite_byte_capture (
    input  wire                           clock_in,
    input  wire                           rst_n,
    input  wire                           draw_enable,
    input  wire                           draw_data_valid,
    input  wire sprite_pkg::sprite_byte_t draw_data,
    input  wire sprite_pkg::color_mode_t  color_mode,
    input  wire sprite_pkg::color_t       palette_offset,
    output logic                          draw_start,
    sprite_byte_if.source                 byte_bus
);

    // Two-bit history of each level, oldest sample in bit 1
    logic [1:0] enable_monitor;
    logic [1:0] valid_monitor;
    logic       byte_edge_next;

    // Data valid is rising at this clock edge
    assign byte_edge_next = draw_data_valid && !valid_monitor[0];

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            enable_monitor <= 2'b00;
            valid_monitor  <= 2'b00;
        end else if (!draw_enable) begin
            // Abort, forget any partial edge
            enable_monitor <= 2'b00;
            valid_monitor  <= 2'b00;
        end else begin
            enable_monitor <= {enable_monitor[0], draw_enable};
            valid_monitor  <= {valid_monitor[0], draw_data_valid};
        end
    end

    // Byte, mode and palette are captured on the same edge the monitor sees the rise
    always_ff @(posedge clock_in) begin
        if (draw_enable && byte_edge_next) begin
            byte_bus.byte_data <= draw_data;
            byte_bus.mode      <= color_mode;
            byte_bus.palette   <= palette_offset;
        end
    end

    // Single cycle pulses while the monitor holds the 01 pattern
    assign draw_start          = (enable_monitor == 2'b01);
    assign byte_bus.byte_strobe = (valid_monitor == 2'b01);

    // No pulse may follow a cycle where draw_enable was sampled low
    assert property (@(posedge clock_in) disable iff (!rst_n)
        (draw_start || byte_bus.byte_strobe) |-> $past(draw_enable))
        else $error("capture pulse after draw_enable was low");

endmodule

`default_nettype wire

/* logic/pixel_unpacker.sv */
`default_nettype none

module pixel_unpacker (
    input  wire                 clock_in,
    input  wire                 rst_n,
    input  wire                 draw_enable,
    sprite_byte_if.sink         byte_bus,
    output logic                pixel_valid,
    output sprite_pkg::color_t  pixel_color,
    output logic                pixel_last
);

    sprite_pkg::unpack_state_t state;
    sprite_pkg::sprite_byte_t  shift_reg;
    sprite_pkg::color_t        field;
    logic [3:0]                pixels_left;
    logic [3:0]                load_count;

    // Pixels held in one byte for the current mode
    always_comb begin
        case (byte_bus.mode)
            sprite_pkg::mode_1bpp:     load_count = 4'd8;
            sprite_pkg::mode_1bpp_alt: load_count = 4'd8;
            sprite_pkg::mode_2bpp:     load_count = 4'd4;
            sprite_pkg::mode_4bpp:     load_count = 4'd2;
        endcase
    end

    // Top field, zero-extended to a palette index
    always_comb begin
        case (byte_bus.mode)
            sprite_pkg::mode_1bpp:     field = {3'b000, shift_reg[7]};
            sprite_pkg::mode_1bpp_alt: field = {3'b000, shift_reg[7]};
            sprite_pkg::mode_2bpp:     field = {2'b00, shift_reg[7:6]};
            sprite_pkg::mode_4bpp:     field = shift_reg[7:4];
        endcase
    end

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            state       <= sprite_pkg::idle;
            pixels_left <= 4'd0;
        end else if (!draw_enable) begin
            state       <= sprite_pkg::idle;
            pixels_left <= 4'd0;
        end else begin
            case (state)
                sprite_pkg::idle: begin
                    if (byte_bus.byte_strobe) begin
                        state       <= sprite_pkg::emitting;
                        pixels_left <= load_count;
                    end
                end
                sprite_pkg::emitting: begin
                    pixels_left <= pixels_left - 4'd1;
                    if (pixels_left == 4'd1) begin
                        state <= sprite_pkg::idle;
                    end
                end
            endcase
        end
    end

    // MSB first, so the used field is shifted out the top
    always_ff @(posedge clock_in) begin
        if (state == sprite_pkg::idle && byte_bus.byte_strobe) begin
            shift_reg <= byte_bus.byte_data;
        end else if (state == sprite_pkg::emitting) begin
            case (byte_bus.mode)
                sprite_pkg::mode_1bpp:     shift_reg <= shift_reg << 1;
                sprite_pkg::mode_1bpp_alt: shift_reg <= shift_reg << 1;
                sprite_pkg::mode_2bpp:     shift_reg <= shift_reg << 2;
                sprite_pkg::mode_4bpp:     shift_reg <= shift_reg << 4;
            endcase
        end
    end

    assign pixel_valid = (state == sprite_pkg::emitting);
    // 4-bit add wraps, giving the offset modulo 16
    assign pixel_color = field + byte_bus.palette;
    assign pixel_last  = pixel_valid && (pixels_left == 4'd1);

    assert property (@(posedge clock_in) disable iff (!rst_n)
        pixels_left <= 4'd8)
        else $error("unpacker pixel count above 8");

    // A new byte must wait until the previous one is fully emitted
    assert property (@(posedge clock_in) disable iff (!rst_n)
        byte_bus.byte_strobe |-> state == sprite_pkg::idle)
        else $error("byte edge ignored while unpacker emitting");

endmodule

`default_nettype wire

/* logic/cursor_addresser.sv */
`default_nettype none

module cursor_addresser (
    input  wire                      clock_in,
    input  wire                      rst_n,
    input  wire                      draw_enable,
    input  wire                      draw_start,
    input  wire sprite_pkg::coord_t  start_x,
    input  wire sprite_pkg::coord_t  start_y,
    input  wire sprite_pkg::coord_t  draw_width,
    input  wire                      pixel_valid,
    input  wire sprite_pkg::color_t  pixel_color,
    input  wire                      pixel_last,
    output logic                     pixel_write_enable,
    output sprite_pkg::fb_addr_t     pixel_write_address,
    output sprite_pkg::color_t       pixel_write_data,
    output logic                     cursor_end_position_valid,
    output sprite_pkg::coord_t       cursor_end_x,
    output sprite_pkg::coord_t       cursor_end_y
);

    sprite_pkg::coord_t   cursor_x;
    sprite_pkg::coord_t   cursor_y;
    sprite_pkg::coord_t   left_bound;
    sprite_pkg::coord_t   right_bound;
    sprite_pkg::coord_t   next_x;
    sprite_pkg::fb_addr_t row_base;
    logic                 end_pending;

    assign next_x = cursor_x + 10'd1;

    // Start of the current row in the framebuffer
    assign row_base = sprite_pkg::fb_addr_t'(cursor_y)
                    * sprite_pkg::fb_addr_t'(sprite_pkg::screen_width);

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            pixel_write_enable        <= 1'b0;
            end_pending               <= 1'b0;
            cursor_end_position_valid <= 1'b0;
        end else if (!draw_enable) begin
            pixel_write_enable        <= 1'b0;
            end_pending               <= 1'b0;
            cursor_end_position_valid <= 1'b0;
        end else begin
            pixel_write_enable        <= pixel_valid;
            // End report trails the last write by one cycle
            end_pending               <= pixel_valid && pixel_last;
            cursor_end_position_valid <= end_pending;
        end
    end

    always_ff @(posedge clock_in) begin
        if (draw_start) begin
            cursor_x    <= start_x;
            cursor_y    <= start_y;
            left_bound  <= start_x;
            right_bound <= start_x + draw_width;
        end else if (pixel_valid) begin
            pixel_write_address <= row_base + sprite_pkg::fb_addr_t'(cursor_x);
            pixel_write_data    <= pixel_color;

            // Row holds draw_width pixels, then back to the left edge
            if (next_x == right_bound) begin
                cursor_x <= left_bound;
                cursor_y <= cursor_y + 10'd1;
            end else begin
                cursor_x <= next_x;
            end
        end

        // Cursor has already advanced past the last pixel here
        if (end_pending) begin
            cursor_end_x <= cursor_x;
            cursor_end_y <= cursor_y;
        end
    end

    // Every pixel from the unpacker must land inside the sprite rectangle
    assert property (@(posedge clock_in) disable iff (!rst_n)
        pixel_valid |-> (cursor_x >= left_bound) && (cursor_x < right_bound))
        else $error("cursor x outside sprite rectangle");

endmodule

`default_nettype wire

/* logic/sprite_engine.sv */
`default_nettype none

module sprite_engine (
    input  wire                           clock_in,
    input  wire                           rst_n,

    input  wire sprite_pkg::coord_t       cursor_start_x,
    input  wire sprite_pkg::coord_t       cursor_start_y,
    input  wire sprite_pkg::coord_t       draw_width,
    input  wire sprite_pkg::color_mode_t  color_mode,
    input  wire sprite_pkg::color_t       palette_offset,

    input  wire                           draw_enable,
    input  wire                           draw_data_valid,
    input  wire sprite_pkg::sprite_byte_t draw_data,

    output logic                          pixel_write_enable,
    output sprite_pkg::fb_addr_t          pixel_write_address,
    output sprite_pkg::color_t            pixel_write_data,

    output logic                          cursor_end_position_valid,
    output sprite_pkg::coord_t            cursor_end_x,
    output sprite_pkg::coord_t            cursor_end_y
);

    logic               draw_start;
    logic               pixel_valid;
    sprite_pkg::color_t pixel_color;
    logic               pixel_last;

    // Captured byte travelling from capture to unpacker
    sprite_byte_if byte_bus ();

    sprite_byte_capture i_capture (
        .clock_in        (clock_in),
        .rst_n           (rst_n),
        .draw_enable     (draw_enable),
        .draw_data_valid (draw_data_valid),
        .draw_data       (draw_data),
        .color_mode      (color_mode),
        .palette_offset  (palette_offset),
        .draw_start      (draw_start),
        .byte_bus        (byte_bus.source)
    );

    pixel_unpacker i_unpacker (
        .clock_in    (clock_in),
        .rst_n       (rst_n),
        .draw_enable (draw_enable),
        .byte_bus    (byte_bus.sink),
        .pixel_valid (pixel_valid),
        .pixel_color (pixel_color),
        .pixel_last  (pixel_last)
    );

    cursor_addresser i_addresser (
        .clock_in                  (clock_in),
        .rst_n                     (rst_n),
        .draw_enable               (draw_enable),
        .draw_start                (draw_start),
        .start_x                   (cursor_start_x),
        .start_y                   (cursor_start_y),
        .draw_width                (draw_width),
        .pixel_valid               (pixel_valid),
        .pixel_color               (pixel_color),
        .pixel_last                (pixel_last),
        .pixel_write_enable        (pixel_write_enable),
        .pixel_write_address       (pixel_write_address),
        .pixel_write_data          (pixel_write_data),
        .cursor_end_position_valid (cursor_end_position_valid),
        .cursor_end_x              (cursor_end_x),
        .cursor_end_y              (cursor_end_y)
    );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clock_in,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clock_in = 1'b0;
        forever #2 clock_in = ~clock_in;
    end

    // Falling edge at 1 ns so the async reset really fires
    initial begin
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (10) @(posedge clock_in);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/sprite_engine_tb.sv */
`default_nettype none

module sprite_engine_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam string vector_path = "bench/sprite_vectors.txt";

    logic                     clock_in;
    logic                     rst_n;
    sprite_pkg::coord_t       cursor_start_x;
    sprite_pkg::coord_t       cursor_start_y;
    sprite_pkg::coord_t       draw_width;
    sprite_pkg::color_mode_t  color_mode;
    sprite_pkg::color_t       palette_offset;
    logic                     draw_enable;
    logic                     draw_data_valid;
    sprite_pkg::sprite_byte_t draw_data;
    logic                     pixel_write_enable;
    sprite_pkg::fb_addr_t     pixel_write_address;
    sprite_pkg::color_t       pixel_write_data;
    logic                     cursor_end_position_valid;
    sprite_pkg::coord_t       cursor_end_x;
    sprite_pkg::coord_t       cursor_end_y;

    // Expected and observed traffic
    int exp_addr[$];
    int exp_data[$];
    int exp_end_x[$];
    int exp_end_y[$];
    int got_addr[$];
    int got_data[$];
    int got_end_x[$];
    int got_end_y[$];

    int error_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int test_number = 0;
    int test_errors_at_start = 0;
    int pending_gap = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    clock_gen i_clock (
        .clock_in (clock_in),
        .rst_n    (rst_n)
    );

    sprite_engine i_dut (
        .clock_in                  (clock_in),
        .rst_n                     (rst_n),
        .cursor_start_x            (cursor_start_x),
        .cursor_start_y            (cursor_start_y),
        .draw_width                (draw_width),
        .color_mode                (color_mode),
        .palette_offset            (palette_offset),
        .draw_enable               (draw_enable),
        .draw_data_valid           (draw_data_valid),
        .draw_data                 (draw_data),
        .pixel_write_enable        (pixel_write_enable),
        .pixel_write_address       (pixel_write_address),
        .pixel_write_data          (pixel_write_data),
        .cursor_end_position_valid (cursor_end_position_valid),
        .cursor_end_x              (cursor_end_x),
        .cursor_end_y              (cursor_end_y)
    );

    // Outputs are registered on the rising edge, so look at them mid-cycle
    always @(negedge clock_in) begin
        if (rst_n === 1'b1) begin
            if (pixel_write_enable === 1'b1) begin
                got_addr.push_back(int'(pixel_write_address));
                got_data.push_back(int'(pixel_write_data));
            end
            if (cursor_end_position_valid === 1'b1) begin
                got_end_x.push_back(int'(cursor_end_x));
                got_end_y.push_back(int'(cursor_end_y));
            end
        end else begin
            assert (pixel_write_enable === 1'b0)
            else begin
                $display("** Error at %0t: pixel_write_enable expected 0, got %b", $time,
                         pixel_write_enable);
                error_count++;
            end
            assert (cursor_end_position_valid === 1'b0)
            else begin
                $display("** Error at %0t: cursor_end_position_valid expected 0, got %b",
                         $time, cursor_end_position_valid);
                error_count++;
            end
        end
    end

    always @(posedge clock_in) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, stimulus did not complete", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic step(input int cycles);
        repeat (cycles) begin
            @(posedge clock_in);
            #1;
        end
    endtask

    function automatic int pixels_per_byte(input sprite_pkg::color_mode_t mode);
        if (mode == 2'b11) begin
            return 2;
        end else if (mode == 2'b10) begin
            return 4;
        end
        return 8;
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
            error_count++;
        end
    endtask

    task automatic finish_test();
        int i;
        step(pending_gap + 4);
        pending_gap = 0;
        assert (got_addr.size() == exp_addr.size())
        else begin
            $display("test %0d: saw %0d pixel writes but expected %0d", test_number,
                     got_addr.size(), exp_addr.size());
            error_count++;
        end
        assert (got_end_x.size() == exp_end_x.size())
        else begin
            $display("test %0d: saw %0d end position pulses but expected %0d", test_number,
                     got_end_x.size(), exp_end_x.size());
            error_count++;
        end
        for (i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            compare_value("pixel_write_address", exp_addr[i], got_addr[i]);
            compare_value("pixel_write_data", exp_data[i], got_data[i]);
        end
        for (i = 0; i < exp_end_x.size() && i < got_end_x.size(); i++) begin
            compare_value("cursor_end_x", exp_end_x[i], got_end_x[i]);
            compare_value("cursor_end_y", exp_end_y[i], got_end_y[i]);
        end
        if (error_count == test_errors_at_start) begin
            tests_passed++;
            $display("test %0d passed", test_number);
        end else begin
            tests_failed++;
            $display("test %0d failed", test_number);
        end
        exp_addr.delete();
        exp_data.delete();
        exp_end_x.delete();
        exp_end_y.delete();
        got_addr.delete();
        got_data.delete();
        got_end_x.delete();
        got_end_y.delete();
    endtask

    // Every draw restarts from a low draw_enable so draw_start always fires
    task automatic start_draw(input int x, input int y, input int w, input int mode,
                              input int pal);
        draw_enable = 1'b0;
        step(2);
        cursor_start_x = sprite_pkg::coord_t'(x);
        cursor_start_y = sprite_pkg::coord_t'(y);
        draw_width     = sprite_pkg::coord_t'(w);
        color_mode     = sprite_pkg::color_mode_t'(mode);
        palette_offset = sprite_pkg::color_t'(pal);
        draw_enable    = 1'b1;
        step(2);
    endtask

    task automatic send_byte(input int value);
        step(pending_gap);
        draw_data       = sprite_pkg::sprite_byte_t'(value);
        draw_data_valid = 1'b1;
        step(1);
        draw_data_valid = 1'b0;
        pending_gap     = pixels_per_byte(color_mode) + 2;
    endtask

    // Count byte lines first to size the timeout
    task automatic count_bytes(output int bytes);
        int    fd;
        string tag;
        string rest;
        bytes = 0;
        fd = $fopen(vector_path, "r");
        while (fd != 0 && $fscanf(fd, "%s", tag) == 1) begin
            if (tag == "byte") begin
                bytes++;
            end
            void'($fgets(rest, fd));
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    initial begin
        int    fd;
        int    bytes;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        string tag;
        string rest;
        bit    in_test;

        cursor_start_x  = '0;
        cursor_start_y  = '0;
        draw_width      = '0;
        color_mode      = '0;
        palette_offset  = '0;
        draw_enable     = 1'b0;
        draw_data_valid = 1'b0;
        draw_data       = '0;
        in_test         = 1'b0;

        count_bytes(bytes);
        cycle_limit = 10 + 12 * bytes + 200;

        fd = $fopen(vector_path, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", vector_path);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            // Draw and byte activity under reset that must not reach the outputs
            wait (rst_n === 1'b0);
            step(2);
            draw_enable = 1'b1;
            step(2);
            draw_data       = 8'hff;
            draw_data_valid = 1'b1;
            step(1);
            draw_data_valid = 1'b0;
            step(2);
            draw_enable = 1'b0;
            wait (rst_n === 1'b1);
            step(1);
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "draw") begin
                    void'($fscanf(fd, "%d %d %d %d %d", a, b, c, d, e));
                    if (in_test) begin
                        finish_test();
                    end
                    in_test = 1'b1;
                    test_number++;
                    test_errors_at_start = error_count;
                    start_draw(a, b, c, d, e);
                end else if (tag == "byte") begin
                    void'($fscanf(fd, "%h", a));
                    send_byte(a);
                end else if (tag == "expect") begin
                    void'($fscanf(fd, "%d %d", a, b));
                    exp_addr.push_back(a);
                    exp_data.push_back(b);
                end else if (tag == "end") begin
                    void'($fscanf(fd, "%d %d", a, b));
                    exp_end_x.push_back(a);
                    exp_end_y.push_back(b);
                end else if (tag == "abort") begin
                    void'($fscanf(fd, "%d", a));
                    step(a);
                    draw_enable = 1'b0;
                    step(3);
                    pending_gap = 0;
                end else begin
                    // Comment line
                    void'($fgets(rest, fd));
                end
            end
            $fclose(fd);
            if (in_test) begin
                finish_test();
            end
            $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed,
                     tests_failed, error_count);
            if (error_count == 0 && tests_failed == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
logic/sprite_pkg.sv
logic/sprite_byte_if.sv
logic/sprite_byte_capture.sv
logic/pixel_unpacker.sv
logic/cursor_addresser.sv
logic/sprite_engine.sv
bench/clock_gen.sv
bench/sprite_engine_tb.sv

/* bench/sprite_vectors.txt */
# draw start_x start_y width mode palette | byte hex_data | abort cycles_after_byte
# expect address color | end x y   (all decimal except byte data)
# 4 bpp, high nibble first, palette wraps modulo 16
draw 10 5 16 3 3
byte a7
expect 3210 13
expect 3211 10
end 12 5
byte 0f
expect 3212 3
expect 3213 2
end 14 5
# 2 bpp, fields MSB first
draw 0 1 8 2 1
byte 1b
expect 640 1
expect 641 2
expect 642 3
expect 643 4
end 4 1
# 1 bpp through mode 01
draw 100 2 20 1 5
byte 96
expect 1380 6
expect 1381 5
expect 1382 5
expect 1383 6
expect 1384 5
expect 1385 6
expect 1386 6
expect 1387 5
end 108 2
# 1 bpp through mode 00, width 8 wraps to the next row at the end
draw 0 0 8 0 0
byte 81
expect 0 1
expect 1 0
expect 2 0
expect 3 0
expect 4 0
expect 5 0
expect 6 0
expect 7 1
end 0 1
# Row wrap with width 3
draw 50 10 3 3 0
byte 12
expect 6450 1
expect 6451 2
end 52 10
byte 34
expect 6452 3
expect 7090 4
end 51 11
byte 56
expect 7091 5
expect 7092 6
end 50 12
# Abort in the middle of a byte, three writes get out
draw 200 3 10 0 2
byte f0
abort 4
expect 2120 3
expect 2121 3
expect 2122 3
# Restart at a new position
draw 7 4 4 3 1
byte 5a
expect 2567 6
expect 2568 11
end 9 4
